/* rtl/rs_defines.svh */
/*
 * Sizing macros for the issue core.
 * Include wherever a tag width, station size or unit latency is needed.
 */

`ifndef RS_DEFINES_SVH
`define RS_DEFINES_SVH

//////////////////////////////
// Tags

// Physical destination tag width
`define RS_TAG_BITS 6

//////////////////////////////
// Stations and units

// Entries in each reservation station
`define RS_ALU_SIZE  4
`define RS_MULT_SIZE 2

// Pipeline depth of each functional unit
`define RS_ALU_LATENCY  1
`define RS_MULT_LATENCY 3

`endif

/* rtl/rs_pkg.sv */
/*
 * Shared types for the issue core.
 * Modules refer to them by scoped name through rs_pkg::.
 */

`include "rs_defines.svh"

package rs_pkg;

    // Physical destination tag
    typedef logic [`RS_TAG_BITS-1:0] tag_t;

    // What dispatch hands to a station
    // Ready bits say the source value already exists
    typedef struct packed {
        tag_t dest_tag;
        tag_t src1_tag;
        tag_t src2_tag;
        logic src1_ready;
        logic src2_ready;
    } dispatch_t;

    // One station slot
    typedef struct packed {
        dispatch_t op;
        logic      valid;
    } rs_entry_t;

endpackage

/* rtl/cdb_if.sv */
/*
 * Common data bus seen by the stations.
 * The arbiter drives the early tag in the grant cycle and the
 * registered broadcast one cycle later.
 */

`timescale 1ns/1ps

interface cdb_if;

    // Early wakeup, same cycle as the grant
    logic         early_valid;
    rs_pkg::tag_t early_tag;

    // Registered broadcast, one cycle after the grant
    logic         cdb_valid;
    rs_pkg::tag_t cdb_tag;

    modport arbiter (
        output early_valid, early_tag, cdb_valid, cdb_tag
    );

    modport listener (
        input early_valid, early_tag, cdb_valid, cdb_tag
    );

endinterface

/* rtl/rs_station.sv */
/*
 * Reservation station working on tags only.
 * Allocates into the lowest free slot, wakes sources from the CDB,
 * issues the lowest fully ready slot and empties on mispredict.
 */

`timescale 1ns/1ps

module rs_station #(
    parameter int size = 4
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               mispredict,
    input  logic               dispatch_valid,
    input  rs_pkg::dispatch_t  dispatch_entry,
    output logic               dispatch_ready,
    cdb_if.listener            cdb,
    output logic               issue_valid,
    output rs_pkg::tag_t       issue_tag,
    input  logic               issue_ready
);

    localparam int idx_bits = (size > 1) ? $clog2(size) : 1;

    rs_pkg::rs_entry_t entries      [size];
    rs_pkg::rs_entry_t entries_next [size];

    logic [size-1:0]     ready_vec;
    logic [size-1:0]     valid_next;
    logic [idx_bits-1:0] free_idx;
    logic [idx_bits-1:0] sel_idx;
    logic                full;
    logic                accept;
    logic                issue_fire;

    // Not-full level comes straight from a flop
    assign dispatch_ready = !full;
    assign accept         = dispatch_valid && dispatch_ready;
    assign issue_fire     = issue_valid && issue_ready;

    //////////////////////////////
    // Select and free search

    // Only registered ready bits count, so a wakeup issues a cycle later
    always_comb begin
        for (int i = 0; i < size; i++) begin
            ready_vec[i] = entries[i].valid && entries[i].op.src1_ready &&
                           entries[i].op.src2_ready;
        end
    end

    // Scan from the top so the lowest index wins
    always_comb begin
        sel_idx     = '0;
        issue_valid = 1'b0;
        free_idx    = '0;
        for (int i = size - 1; i >= 0; i--) begin
            if (ready_vec[i]) begin
                sel_idx     = idx_bits'(i);
                issue_valid = 1'b1;
            end
            if (!entries[i].valid) begin
                free_idx = idx_bits'(i);
            end
        end
    end

    assign issue_tag = entries[sel_idx].op.dest_tag;

    //////////////////////////////
    // Next state

    always_comb begin
        for (int i = 0; i < size; i++) begin
            entries_next[i] = entries[i];
        end

        // Issued slot frees up
        if (issue_fire) begin
            entries_next[sel_idx].valid = 1'b0;
        end

        // New entry, slot was free in the registered state
        if (accept) begin
            entries_next[free_idx].op    = dispatch_entry;
            entries_next[free_idx].valid = 1'b1;
        end

        // Wakeup covers the new entry too
        // Registered broadcast catches a tag whose early cycle came before allocation
        for (int i = 0; i < size; i++) begin
            if ((cdb.early_valid && cdb.early_tag == entries_next[i].op.src1_tag) ||
                (cdb.cdb_valid && cdb.cdb_tag == entries_next[i].op.src1_tag)) begin
                entries_next[i].op.src1_ready = 1'b1;
            end
            if ((cdb.early_valid && cdb.early_tag == entries_next[i].op.src2_tag) ||
                (cdb.cdb_valid && cdb.cdb_tag == entries_next[i].op.src2_tag)) begin
                entries_next[i].op.src2_ready = 1'b1;
            end
            valid_next[i] = entries_next[i].valid;
        end
    end

    //////////////////////////////
    // State

    // Flush drops every slot, ready returns next cycle
    always_ff @(posedge clock) begin
        if (reset || mispredict) begin
            full <= 1'b0;
            for (int i = 0; i < size; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            full <= &valid_next;
            for (int i = 0; i < size; i++) begin
                entries[i] <= entries_next[i];
            end
        end
    end

endmodule

/* rtl/fu_pipe.sv */
/*
 * Stand-in for a fixed-latency functional unit.
 * Tags walk a chain of stages, and the last one waits for the CDB grant.
 * Bubbles close up under back-pressure.
 */

`timescale 1ns/1ps

module fu_pipe #(
    parameter int latency = 1
) (
    input  logic         clock,
    input  logic         reset,
    input  logic         mispredict,
    input  logic         issue_valid,
    input  rs_pkg::tag_t issue_tag,
    output logic         issue_ready,
    output logic         done_valid,
    output rs_pkg::tag_t done_tag,
    input  logic         done_grant
);

    logic [latency-1:0] stage_valid;
    rs_pkg::tag_t       stage_tag [latency];

    // Stage can take new content this edge
    logic [latency-1:0] stage_free;

    // Free if empty or its content moves on
    always_comb begin
        stage_free[latency-1] = !stage_valid[latency-1] || done_grant;
        for (int i = latency - 2; i >= 0; i--) begin
            stage_free[i] = !stage_valid[i] || stage_free[i+1];
        end
    end

    assign issue_ready = stage_free[0];
    assign done_valid  = stage_valid[latency-1];
    assign done_tag    = stage_tag[latency-1];

    //////////////////////////////
    // Valid chain

    always_ff @(posedge clock) begin
        if (reset || mispredict) begin
            stage_valid <= '0;
        end else begin
            if (stage_free[0]) begin
                stage_valid[0] <= issue_valid;
            end
            for (int i = 1; i < latency; i++) begin
                if (stage_free[i]) begin
                    stage_valid[i] <= stage_valid[i-1];
                end
            end
        end
    end

    // Tag chain follows the same moves
    always_ff @(posedge clock) begin
        if (stage_free[0]) begin
            stage_tag[0] <= issue_tag;
        end
        for (int i = 1; i < latency; i++) begin
            if (stage_free[i]) begin
                stage_tag[i] <= stage_tag[i-1];
            end
        end
    end

endmodule

/* rtl/cdb_arbiter.sv */
/*
 * CDB arbiter for the two functional units.
 * Grants one finished tag per cycle, multiply first, drives the early
 * tag in the grant cycle and registers the broadcast for the next.
 */

`timescale 1ns/1ps

module cdb_arbiter (
    input  logic         clock,
    input  logic         reset,
    input  logic         mispredict,
    input  logic         alu_done_valid,
    input  rs_pkg::tag_t alu_done_tag,
    output logic         alu_done_grant,
    input  logic         mult_done_valid,
    input  rs_pkg::tag_t mult_done_tag,
    output logic         mult_done_grant,
    cdb_if.arbiter       cdb
);

    //////////////////////////////
    // Grant

    // Longer pipe first, ALU waits a cycle on a collision
    assign mult_done_grant = mult_done_valid;
    assign alu_done_grant  = alu_done_valid && !mult_done_valid;

    // Early tag is the granted result
    assign cdb.early_valid = mult_done_valid || alu_done_valid;
    assign cdb.early_tag   = mult_done_valid ? mult_done_tag : alu_done_tag;

    //////////////////////////////
    // Broadcast register

    // Broadcast lasts one cycle, dropped on flush
    always_ff @(posedge clock) begin
        if (reset || mispredict) begin
            cdb.cdb_valid <= 1'b0;
        end else begin
            cdb.cdb_valid <= cdb.early_valid;
        end
    end

    // Tag only means something with cdb_valid
    always_ff @(posedge clock) begin
        cdb.cdb_tag <= cdb.early_tag;
    end

endmodule

/* rtl/issue_core.sv */
/*
 * Top of the tag-only scheduling core.
 * Two stations feed two units, and the arbiter closes the loop
 * through the CDB. Dispatch and broadcast are plain ports.
 */

`timescale 1ns/1ps

`include "rs_defines.svh"

module issue_core (
    input  logic              clock,
    input  logic              reset,
    input  logic              mispredict,
    input  logic              alu_dispatch_valid,
    input  logic              mult_dispatch_valid,
    input  rs_pkg::dispatch_t alu_dispatch_entry,
    input  rs_pkg::dispatch_t mult_dispatch_entry,
    output logic              alu_dispatch_ready,
    output logic              mult_dispatch_ready,
    output logic              cdb_valid,
    output rs_pkg::tag_t      cdb_tag
);

    cdb_if cdb_bus ();

    // Station to unit
    logic         alu_issue_valid;
    rs_pkg::tag_t alu_issue_tag;
    logic         alu_issue_ready;
    logic         mult_issue_valid;
    rs_pkg::tag_t mult_issue_tag;
    logic         mult_issue_ready;

    // Unit to arbiter
    logic         alu_done_valid;
    rs_pkg::tag_t alu_done_tag;
    logic         alu_done_grant;
    logic         mult_done_valid;
    rs_pkg::tag_t mult_done_tag;
    logic         mult_done_grant;

    //////////////////////////////
    // Stations

    rs_station #(.size(`RS_ALU_SIZE)) rs_alu (
        .clock          (clock),
        .reset          (reset),
        .mispredict     (mispredict),
        .dispatch_valid (alu_dispatch_valid),
        .dispatch_entry (alu_dispatch_entry),
        .dispatch_ready (alu_dispatch_ready),
        .cdb            (cdb_bus.listener),
        .issue_valid    (alu_issue_valid),
        .issue_tag      (alu_issue_tag),
        .issue_ready    (alu_issue_ready)
    );

    rs_station #(.size(`RS_MULT_SIZE)) rs_mult (
        .clock          (clock),
        .reset          (reset),
        .mispredict     (mispredict),
        .dispatch_valid (mult_dispatch_valid),
        .dispatch_entry (mult_dispatch_entry),
        .dispatch_ready (mult_dispatch_ready),
        .cdb            (cdb_bus.listener),
        .issue_valid    (mult_issue_valid),
        .issue_tag      (mult_issue_tag),
        .issue_ready    (mult_issue_ready)
    );

    //////////////////////////////
    // Units and arbiter

    fu_pipe #(.latency(`RS_ALU_LATENCY)) fu_alu (
        .clock       (clock),
        .reset       (reset),
        .mispredict  (mispredict),
        .issue_valid (alu_issue_valid),
        .issue_tag   (alu_issue_tag),
        .issue_ready (alu_issue_ready),
        .done_valid  (alu_done_valid),
        .done_tag    (alu_done_tag),
        .done_grant  (alu_done_grant)
    );

    fu_pipe #(.latency(`RS_MULT_LATENCY)) fu_mult (
        .clock       (clock),
        .reset       (reset),
        .mispredict  (mispredict),
        .issue_valid (mult_issue_valid),
        .issue_tag   (mult_issue_tag),
        .issue_ready (mult_issue_ready),
        .done_valid  (mult_done_valid),
        .done_tag    (mult_done_tag),
        .done_grant  (mult_done_grant)
    );

    cdb_arbiter arbiter (
        .clock           (clock),
        .reset           (reset),
        .mispredict      (mispredict),
        .alu_done_valid  (alu_done_valid),
        .alu_done_tag    (alu_done_tag),
        .alu_done_grant  (alu_done_grant),
        .mult_done_valid (mult_done_valid),
        .mult_done_tag   (mult_done_tag),
        .mult_done_grant (mult_done_grant),
        .cdb             (cdb_bus.arbiter)
    );

    // Registered broadcast out to the ports
    assign cdb_valid = cdb_bus.cdb_valid;
    assign cdb_tag   = cdb_bus.cdb_tag;

endmodule

/* bench/tb_clock.sv */
/*
 * Free-running clock for the testbench.
 * Starts low, so the first rising edge comes half a period in.
 */

`timescale 1ns/1ps

module tb_clock #(
    parameter int half_period = 50
) (
    output logic clock
);

    // 100 ns period with the default half period
    initial begin
        clock = 1'b0;
        forever #(half_period) clock = ~clock;
    end

endmodule

/* bench/issue_core_assertions.sv */
/*
 * Concurrent checks on CDB ordering, bound into issue_core.
 * Follows dispatched, waiting and broadcast tags from the top-level ports.
 */

`timescale 1ns/1ps

`include "rs_defines.svh"

module issue_core_assertions (
    input logic              clock,
    input logic              reset,
    input logic              mispredict,
    input logic              alu_dispatch_valid,
    input logic              alu_dispatch_ready,
    input rs_pkg::dispatch_t alu_dispatch_entry,
    input logic              mult_dispatch_valid,
    input logic              mult_dispatch_ready,
    input rs_pkg::dispatch_t mult_dispatch_entry,
    input logic              cdb_valid,
    input rs_pkg::tag_t      cdb_tag
);

    localparam int num_tags = 2 ** `RS_TAG_BITS;

    // Dispatched since the last flush
    logic [num_tags-1:0] dispatched_vec;
    // Already on the CDB since its dispatch
    logic [num_tags-1:0] broadcast_vec;
    // Source the tag still waits for
    logic [num_tags-1:0] wait1_vec;
    logic [num_tags-1:0] wait2_vec;
    rs_pkg::tag_t        src1_of [num_tags];
    rs_pkg::tag_t        src2_of [num_tags];

    logic alu_accept;
    logic mult_accept;

    // Stations drop the entry on a flush edge
    assign alu_accept  = alu_dispatch_valid && alu_dispatch_ready && !mispredict;
    assign mult_accept = mult_dispatch_valid && mult_dispatch_ready && !mispredict;

    // A broadcast in the accept cycle already covers the source
    function automatic logic source_owed(input logic ready, input rs_pkg::tag_t src,
                                         input logic bus_valid, input rs_pkg::tag_t bus_tag);
        return !ready && !(bus_valid && bus_tag == src);
    endfunction

    //////////////////////////////
    // Tag bookkeeping

    always_ff @(posedge clock) begin
        if (reset || mispredict) begin
            dispatched_vec <= '0;
            broadcast_vec  <= '0;
            wait1_vec      <= '0;
            wait2_vec      <= '0;
        end else begin
            if (cdb_valid) begin
                broadcast_vec[cdb_tag] <= 1'b1;
                for (int t = 0; t < num_tags; t++) begin
                    if (src1_of[t] == cdb_tag) begin
                        wait1_vec[t] <= 1'b0;
                    end
                    if (src2_of[t] == cdb_tag) begin
                        wait2_vec[t] <= 1'b0;
                    end
                end
            end
            // New dispatch overrides anything above for its own tag
            if (alu_accept) begin
                dispatched_vec[alu_dispatch_entry.dest_tag] <= 1'b1;
                broadcast_vec[alu_dispatch_entry.dest_tag]  <= 1'b0;
                wait1_vec[alu_dispatch_entry.dest_tag] <= source_owed(
                    alu_dispatch_entry.src1_ready, alu_dispatch_entry.src1_tag,
                    cdb_valid, cdb_tag);
                wait2_vec[alu_dispatch_entry.dest_tag] <= source_owed(
                    alu_dispatch_entry.src2_ready, alu_dispatch_entry.src2_tag,
                    cdb_valid, cdb_tag);
            end
            if (mult_accept) begin
                dispatched_vec[mult_dispatch_entry.dest_tag] <= 1'b1;
                broadcast_vec[mult_dispatch_entry.dest_tag]  <= 1'b0;
                wait1_vec[mult_dispatch_entry.dest_tag] <= source_owed(
                    mult_dispatch_entry.src1_ready, mult_dispatch_entry.src1_tag,
                    cdb_valid, cdb_tag);
                wait2_vec[mult_dispatch_entry.dest_tag] <= source_owed(
                    mult_dispatch_entry.src2_ready, mult_dispatch_entry.src2_tag,
                    cdb_valid, cdb_tag);
            end
        end
    end

    // Source tags per destination
    always_ff @(posedge clock) begin
        if (alu_accept) begin
            src1_of[alu_dispatch_entry.dest_tag] <= alu_dispatch_entry.src1_tag;
            src2_of[alu_dispatch_entry.dest_tag] <= alu_dispatch_entry.src2_tag;
        end
        if (mult_accept) begin
            src1_of[mult_dispatch_entry.dest_tag] <= mult_dispatch_entry.src1_tag;
            src2_of[mult_dispatch_entry.dest_tag] <= mult_dispatch_entry.src2_tag;
        end
    end

    //////////////////////////////
    // Properties

    // Live tag, and only its first broadcast
    broadcast_once: assert property (
        @(posedge clock) disable iff (reset)
        cdb_valid |-> dispatched_vec[cdb_tag] && !broadcast_vec[cdb_tag]
    ) else $error("CDB tag %0d was never dispatched or was broadcast twice", cdb_tag);

    // Producers come first
    sources_first: assert property (
        @(posedge clock) disable iff (reset)
        cdb_valid |-> !wait1_vec[cdb_tag] && !wait2_vec[cdb_tag]
    ) else $error("CDB tag %0d broadcast before one of its sources", cdb_tag);

    // Stations, units and the broadcast register all empty on a flush
    // A new dispatch needs three more edges to reach the CDB
    flush_quiet: assert property (
        @(posedge clock) disable iff (reset)
        ($past(mispredict) || $past(mispredict, 2) || $past(mispredict, 3)) |-> !cdb_valid
    ) else $error("CDB broadcast within three cycles of a mispredict");

endmodule

bind issue_core issue_core_assertions cdb_checks (
    .clock               (clock),
    .reset               (reset),
    .mispredict          (mispredict),
    .alu_dispatch_valid  (alu_dispatch_valid),
    .alu_dispatch_ready  (alu_dispatch_ready),
    .alu_dispatch_entry  (alu_dispatch_entry),
    .mult_dispatch_valid (mult_dispatch_valid),
    .mult_dispatch_ready (mult_dispatch_ready),
    .mult_dispatch_entry (mult_dispatch_entry),
    .cdb_valid           (cdb_valid),
    .cdb_tag             (cdb_tag)
);

/* bench/issue_core_tb.sv */
/*
 * Testbench for issue_core.
 * Random dependency chains, ALU back-pressure, a multiply burst and flushes.
 * Ordering rules sit in the bound assertions, end counts are checked here.
 */

`timescale 1ns/1ps

`include "rs_defines.svh"

module issue_core_tb;

    localparam int num_tags        = 2 ** `RS_TAG_BITS;
    localparam int random_ops      = 60;
    localparam int burst_ops       = 8;
    localparam int planned_ops     = 2 * random_ops + `RS_ALU_SIZE + 2 * burst_ops;
    localparam int watchdog_cycles = 40 * planned_ops + 200;

    // Testbench view of each tag
    localparam logic [1:0] tag_free     = 2'd0;
    localparam logic [1:0] tag_reserved = 2'd1;
    localparam logic [1:0] tag_pending  = 2'd2;
    localparam logic [1:0] tag_done     = 2'd3;

    logic              clock;
    logic              reset;
    logic              mispredict;
    logic              alu_dispatch_valid;
    logic              mult_dispatch_valid;
    rs_pkg::dispatch_t alu_dispatch_entry;
    rs_pkg::dispatch_t mult_dispatch_entry;
    logic              alu_dispatch_ready;
    logic              mult_dispatch_ready;
    logic              cdb_valid;
    rs_pkg::tag_t      cdb_tag;

    logic [1:0]   tag_state [num_tags];
    logic [31:0]  rng_state;
    rs_pkg::tag_t next_tag;
    rs_pkg::tag_t last_dest;
    rs_pkg::tag_t last_broadcast;
    int           dispatch_count;
    int           flush_count;
    int           broadcast_count;
    int           error_count;

    tb_clock clock_gen (
        .clock (clock)
    );

    issue_core dut (
        .clock               (clock),
        .reset               (reset),
        .mispredict          (mispredict),
        .alu_dispatch_valid  (alu_dispatch_valid),
        .mult_dispatch_valid (mult_dispatch_valid),
        .alu_dispatch_entry  (alu_dispatch_entry),
        .mult_dispatch_entry (mult_dispatch_entry),
        .alu_dispatch_ready  (alu_dispatch_ready),
        .mult_dispatch_ready (mult_dispatch_ready),
        .cdb_valid           (cdb_valid),
        .cdb_tag             (cdb_tag)
    );

    //////////////////////////////
    // Helpers

    function automatic logic [31:0] xorshift32(input logic [31:0] value);
        logic [31:0] x;
        x = value;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_random(output logic [31:0] value);
        rng_state = xorshift32(rng_state);
        value = rng_state;
    endtask

    // Inputs change 1 ns after the edge
    task automatic idle_cycle();
        @(posedge clock);
        #1;
    endtask

    function automatic int count_pending();
        int n;
        n = 0;
        for (int t = 0; t < num_tags; t++) begin
            if (tag_state[t] == tag_pending) begin
                n++;
            end
        end
        return n;
    endfunction

    // Counter skips tags still in flight
    task automatic allocate_tag(output rs_pkg::tag_t tag);
        while (tag_state[next_tag] == tag_pending || tag_state[next_tag] == tag_reserved) begin
            next_tag = next_tag + 1'b1;
        end
        tag = next_tag;
        next_tag = next_tag + 1'b1;
    endtask

    // Half the time chain on the latest dispatch
    // Ready only when the tag has been seen on the CDB
    task automatic pick_source(output rs_pkg::tag_t tag, output logic ready);
        logic [31:0] r;
        next_random(r);
        if (r[0]) begin
            tag = last_dest;
        end else begin
            tag = r[6:1];
        end
        if (tag_state[tag] != tag_pending && tag_state[tag] != tag_done) begin
            tag = last_broadcast;
        end
        ready = (tag_state[tag] != tag_pending);
    endtask

    task automatic make_op(input logic independent, output rs_pkg::dispatch_t op);
        rs_pkg::tag_t dest;
        rs_pkg::tag_t src1;
        rs_pkg::tag_t src2;
        logic         ready1;
        logic         ready2;
        allocate_tag(dest);
        if (independent) begin
            src1   = last_broadcast;
            src2   = last_broadcast;
            ready1 = (tag_state[last_broadcast] != tag_pending);
            ready2 = ready1;
        end else begin
            pick_source(src1, ready1);
            pick_source(src2, ready2);
        end
        op.dest_tag   = dest;
        op.src1_tag   = src1;
        op.src2_tag   = src2;
        op.src1_ready = ready1;
        op.src2_ready = ready2;
    endtask

    task automatic wait_for_ready(input logic to_mult);
        while ((to_mult && !mult_dispatch_ready) || (!to_mult && !alu_dispatch_ready)) begin
            idle_cycle();
        end
    endtask

    // Callers only raise a valid whose ready is already high
    task automatic dispatch_cycle(input logic alu_go, input rs_pkg::dispatch_t alu_op,
                                  input logic mult_go, input rs_pkg::dispatch_t mult_op);
        alu_dispatch_valid  = alu_go;
        alu_dispatch_entry  = alu_op;
        mult_dispatch_valid = mult_go;
        mult_dispatch_entry = mult_op;
        idle_cycle();
        alu_dispatch_valid  = 1'b0;
        mult_dispatch_valid = 1'b0;
        if (alu_go) begin
            tag_state[alu_op.dest_tag] = tag_pending;
            last_dest = alu_op.dest_tag;
            dispatch_count++;
        end
        if (mult_go) begin
            tag_state[mult_op.dest_tag] = tag_pending;
            last_dest = mult_op.dest_tag;
            dispatch_count++;
        end
    endtask

    task automatic drain();
        while (count_pending() != 0) begin
            idle_cycle();
        end
        repeat (4) idle_cycle();
    endtask

    task automatic check_high(input string name, input logic actual);
        if (actual !== 1'b1) begin
            error_count++;
            $display("Fail %s: expected 1 actual %0b", name, actual);
        end
    endtask

    //////////////////////////////
    // Tests

    // One op to a random station, then a short random gap
    task automatic random_op();
        logic [31:0]       r;
        logic              to_mult;
        rs_pkg::dispatch_t op;
        next_random(r);
        to_mult = (r[1:0] == 2'b00);
        wait_for_ready(to_mult);
        make_op(1'b0, op);
        if (to_mult) begin
            dispatch_cycle(1'b0, '0, 1'b1, op);
        end else begin
            dispatch_cycle(1'b1, op, 1'b0, '0);
        end
        if (r[3:2] == 2'b00) begin
            repeat (r[5:4]) idle_cycle();
        end
    endtask

    // Whatever was pending when the flush edge came is lost
    task automatic flush_all();
        mispredict = 1'b1;
        idle_cycle();
        mispredict = 1'b0;
        for (int t = 0; t < num_tags; t++) begin
            if (tag_state[t] == tag_pending) begin
                flush_count++;
                tag_state[t] = tag_free;
            end else if (tag_state[t] == tag_reserved) begin
                tag_state[t] = tag_free;
            end
        end
        idle_cycle();
        check_high("flush_alu_ready", alu_dispatch_ready);
        check_high("flush_mult_ready", mult_dispatch_ready);
    endtask

    // Every ALU entry waits on a tag that never comes
    task automatic check_backpressure();
        rs_pkg::tag_t      blocker;
        rs_pkg::tag_t      dest;
        rs_pkg::dispatch_t op;
        int                accepted;
        drain();
        allocate_tag(blocker);
        tag_state[blocker] = tag_reserved;
        accepted = 0;
        while (alu_dispatch_ready && accepted < `RS_ALU_SIZE + 2) begin
            allocate_tag(dest);
            op.dest_tag   = dest;
            op.src1_tag   = blocker;
            op.src2_tag   = blocker;
            op.src1_ready = 1'b0;
            op.src2_ready = 1'b0;
            dispatch_cycle(1'b1, op, 1'b0, '0);
            accepted++;
        end
        if (accepted != `RS_ALU_SIZE) begin
            error_count++;
            $display("Fail backpressure: accepted expected %0d actual %0d",
                     `RS_ALU_SIZE, accepted);
        end
        flush_all();
    endtask

    // Independent multiplies back to back, ALU ops alongside when there is room
    task automatic mult_burst();
        rs_pkg::dispatch_t mult_op;
        rs_pkg::dispatch_t alu_op;
        logic              alu_go;
        for (int i = 0; i < burst_ops; i++) begin
            wait_for_ready(1'b1);
            make_op(1'b1, mult_op);
            alu_go = alu_dispatch_ready;
            alu_op = '0;
            if (alu_go) begin
                make_op(1'b0, alu_op);
            end
            dispatch_cycle(alu_go, alu_op, 1'b1, mult_op);
        end
    endtask

    //////////////////////////////
    // CDB monitor and watchdog

    // Mid-cycle, away from the edge where cdb_valid changes
    always @(negedge clock) begin
        if (!reset && cdb_valid) begin
            broadcast_count++;
            last_broadcast = cdb_tag;
            if (tag_state[cdb_tag] == tag_pending) begin
                tag_state[cdb_tag] = tag_done;
            end
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clock);
        $display("Watchdog expired after %0d cycles, tags stopped reaching the CDB",
                 watchdog_cycles);
        $display("TEST FAILED");
        $finish;
    end

    //////////////////////////////
    // Main sequence

    initial begin
        reset               = 1'b1;
        mispredict          = 1'b0;
        alu_dispatch_valid  = 1'b0;
        mult_dispatch_valid = 1'b0;
        alu_dispatch_entry  = '0;
        mult_dispatch_entry = '0;
        rng_state           = 32'h7b3311e1;
        next_tag            = '0;
        last_dest           = '0;
        last_broadcast      = '0;
        dispatch_count      = 0;
        flush_count         = 0;
        broadcast_count     = 0;
        error_count         = 0;
        for (int t = 0; t < num_tags; t++) begin
            tag_state[t] = tag_free;
        end

        repeat (3) @(posedge clock);
        #1;
        reset = 1'b0;

        for (int i = 0; i < random_ops; i++) begin
            random_op();
        end
        drain();
        check_backpressure();
        mult_burst();
        drain();

        // Flush in the middle of live traffic
        for (int i = 0; i < random_ops; i++) begin
            if (i == random_ops / 2) begin
                flush_all();
            end
            random_op();
        end
        drain();

        if (broadcast_count != dispatch_count - flush_count) begin
            error_count++;
            $display("Fail broadcast_count: expected %0d actual %0d",
                     dispatch_count - flush_count, broadcast_count);
        end
        $display("Summary: %0d dispatched, %0d flushed, %0d broadcast, %0d errors",
                 dispatch_count, flush_count, broadcast_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+rtl
rtl/rs_pkg.sv
rtl/cdb_if.sv
rtl/rs_station.sv
rtl/fu_pipe.sv
rtl/cdb_arbiter.sv
rtl/issue_core.sv
bench/tb_clock.sv
bench/issue_core_assertions.sv
bench/issue_core_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the issue core testbench with Verilator
# The run counts as failed when the log holds the fail message

log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module issue_core_tb \
    -f vlog.f -o issue_core_sim > "$log" 2>&1 &&
    ./obj_dir/issue_core_sim >> "$log" 2>&1 ||
    echo "TEST FAILED" >> "$log"

cat "$log"
grep -q "TEST FAILED" "$log" && exit 1 || exit 0
